// ==== Bender.yml ====
package:
  name: chip_dbg

sources:
  - files:
      - src/chip_dbg_pkg.sv
      - src/dps_pad_mux.sv
      - src/ram_main.sv
      - src/sw_mail_snoop.sv
      - src/test_status_fsm.sv
      - src/test_timer.sv
      - src/chip_dbg_top.sv
  - target: test
    files:
      - test/chip_dbg_chk.sv
      - test/tb_chip_dbg.sv

// ==== src/chip_dbg_pkg.sv ====
/*
 * Debug and test-status package
 * Shared widths, snoop word addresses, timeout length and enums
 */

package chip_dbg_pkg;

  // RAM geometry
  localparam int unsigned RAM_AW = 6;
  localparam int unsigned DW     = 32;

  // Agreed mailbox words at the top of the RAM
  localparam logic [RAM_AW-1:0] SW_STATUS_ADDR = RAM_AW'(62);
  localparam logic [RAM_AW-1:0] SW_LOG_ADDR    = RAM_AW'(63);

  // Test timeout
  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam int unsigned TMR_W          = 8;

  // Terminal count of the timer, TIMEOUT_CYCLES-1
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(TIMEOUT_CYCLES - 1);

  // Low half of a status word written by software
  typedef enum logic [15:0] {
    ST_IN_BOOT = 16'hb090,
    ST_IN_TEST = 16'h4354,
    ST_PASSED  = 16'h900d,
    ST_FAILED  = 16'hbaad
  } sw_status_e;

  // Test phase as seen by the status FSM
  typedef enum logic [2:0] {
    TS_RESET,
    TS_BOOT,
    TS_TEST,
    TS_PASS,
    TS_FAIL,
    TS_TIMEOUT
  } test_state_e;

endpackage

// ==== src/chip_dbg_top.sv ====
/*
 * Chip debug and test-status top
 * Pad sharing, main RAM, mailbox snoop, status FSM and timeout timer
 */

`timescale 1ns/1ps

module chip_dbg_top (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            jtag_spi_n_i,
  input  logic                            jtag_tck_i,
  input  logic                            jtag_tms_i,
  input  logic                            jtag_tdi_i,
  input  logic                            jtag_trst_n_i,
  input  logic                            spi_sck_i,
  input  logic                            spi_csb_i,
  input  logic                            spi_sdi_i,
  output logic                            jtag_tdo_o,
  output logic                            spi_sdo_o,
  input  logic                            dps_i,
  output logic [4:0]                      dps_o,
  input  logic                            ram_req_i,
  input  logic                            ram_write_i,
  input  logic [chip_dbg_pkg::RAM_AW-1:0] ram_addr_i,
  input  logic [chip_dbg_pkg::DW-1:0]     ram_wdata_i,
  output logic [chip_dbg_pkg::DW-1:0]     ram_rdata_o,
  output logic                            ram_rvalid_o,
  output logic                            log_valid_o,
  output logic [chip_dbg_pkg::DW-1:0]     log_data_o,
  output chip_dbg_pkg::test_state_e       test_state_o,
  output logic                            test_done_o,
  output logic                            test_passed_o,
  output logic [chip_dbg_pkg::TMR_W-1:0]  test_elapsed_o,
  output logic                            dps_sel_jtag_o
);

  logic                     status_valid;
  chip_dbg_pkg::sw_status_e status_val;
  logic                     tmr_run;
  logic                     tmr_expire;

  dps_pad_mux u_pad_mux (
    .clk           (clk),
    .rst_i         (rst_i),
    .jtag_spi_n_i  (jtag_spi_n_i),
    .jtag_tck_i    (jtag_tck_i),
    .jtag_tms_i    (jtag_tms_i),
    .jtag_tdi_i    (jtag_tdi_i),
    .jtag_trst_n_i (jtag_trst_n_i),
    .spi_sck_i     (spi_sck_i),
    .spi_csb_i     (spi_csb_i),
    .spi_sdi_i     (spi_sdi_i),
    .dps_i         (dps_i),
    .dps_o         (dps_o),
    .jtag_tdo_o    (jtag_tdo_o),
    .spi_sdo_o     (spi_sdo_o),
    .sel_jtag_o    (dps_sel_jtag_o)
  );

  ram_main u_ram (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (ram_req_i),
    .write_i  (ram_write_i),
    .addr_i   (ram_addr_i),
    .wdata_i  (ram_wdata_i),
    .rdata_o  (ram_rdata_o),
    .rvalid_o (ram_rvalid_o)
  );

  // Snoop sits on the same port as the RAM
  sw_mail_snoop u_snoop (
    .clk            (clk),
    .rst_i          (rst_i),
    .req_i          (ram_req_i),
    .write_i        (ram_write_i),
    .addr_i         (ram_addr_i),
    .wdata_i        (ram_wdata_i),
    .status_valid_o (status_valid),
    .status_val_o   (status_val),
    .log_valid_o    (log_valid_o),
    .log_data_o     (log_data_o)
  );

  test_status_fsm u_fsm (
    .clk            (clk),
    .rst_i          (rst_i),
    .status_valid_i (status_valid),
    .status_val_i   (status_val),
    .expire_i       (tmr_expire),
    .state_o        (test_state_o),
    .run_o          (tmr_run),
    .test_done_o    (test_done_o),
    .test_passed_o  (test_passed_o)
  );

  test_timer u_timer (
    .clk       (clk),
    .rst_i     (rst_i),
    .run_i     (tmr_run),
    .expire_o  (tmr_expire),
    .elapsed_o (test_elapsed_o)
  );

endmodule

// ==== src/dps_pad_mux.sv ====
/*
 * Debug pad mux
 * Latches the JTAG/SPI strap during reset and shares the debug pads
 */

`timescale 1ns/1ps

module dps_pad_mux (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       jtag_spi_n_i,
  input  logic       jtag_tck_i,
  input  logic       jtag_tms_i,
  input  logic       jtag_tdi_i,
  input  logic       jtag_trst_n_i,
  input  logic       spi_sck_i,
  input  logic       spi_csb_i,
  input  logic       spi_sdi_i,
  input  logic       dps_i,
  output logic [4:0] dps_o,
  output logic       jtag_tdo_o,
  output logic       spi_sdo_o,
  output logic       sel_jtag_o
);

  logic sel_jtag_q;

  // Strap tracks the pin only while reset is held
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sel_jtag_q <= jtag_spi_n_i;
    end
  end

  assign sel_jtag_o = sel_jtag_q;

  // Host to pads
  assign dps_o[0] = sel_jtag_q ? jtag_tck_i : spi_sck_i;
  assign dps_o[1] = sel_jtag_q ? jtag_tdi_i : spi_sdi_i;
  assign dps_o[2] = 1'b0;  // return pad, input only
  assign dps_o[3] = sel_jtag_q ? jtag_tms_i : spi_csb_i;
  assign dps_o[4] = jtag_trst_n_i;

  // Return pad goes to the selected host only
  assign jtag_tdo_o = sel_jtag_q ? dps_i : 1'b0;
  assign spi_sdo_o  = sel_jtag_q ? 1'b0 : dps_i;

endmodule

// ==== src/ram_main.sv ====
/*
 * Main RAM
 * Single-port word memory with registered read data and valid pulse
 */

`timescale 1ns/1ps

module ram_main (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic                          write_i,
  input  logic [chip_dbg_pkg::RAM_AW-1:0] addr_i,
  input  logic [chip_dbg_pkg::DW-1:0]     wdata_i,
  output logic [chip_dbg_pkg::DW-1:0]     rdata_o,
  output logic                          rvalid_o
);

  localparam int unsigned DEPTH = 2 ** chip_dbg_pkg::RAM_AW;

  logic [chip_dbg_pkg::DW-1:0] mem_q [DEPTH];
  logic [chip_dbg_pkg::DW-1:0] rdata_q;
  logic                        rvalid_q;

  // Storage and read data path
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (write_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  // Read strobe, one cycle after the request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i & ~write_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

// ==== src/sw_mail_snoop.sv ====
/*
 * Software mailbox snoop
 * Decodes RAM writes to the status and log words into pulses
 */

`timescale 1ns/1ps

module sw_mail_snoop (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            req_i,
  input  logic                            write_i,
  input  logic [chip_dbg_pkg::RAM_AW-1:0] addr_i,
  input  logic [chip_dbg_pkg::DW-1:0]     wdata_i,
  output logic                            status_valid_o,
  output chip_dbg_pkg::sw_status_e        status_val_o,
  output logic                            log_valid_o,
  output logic [chip_dbg_pkg::DW-1:0]     log_data_o
);

  logic                     wr_hit;
  logic                     status_hit;
  logic                     log_hit;
  logic                     status_valid_q;
  logic                     log_valid_q;
  chip_dbg_pkg::sw_status_e status_val_q;
  logic [chip_dbg_pkg::DW-1:0] log_data_q;

  assign wr_hit     = req_i & write_i;
  assign status_hit = wr_hit && (addr_i == chip_dbg_pkg::SW_STATUS_ADDR);
  assign log_hit    = wr_hit && (addr_i == chip_dbg_pkg::SW_LOG_ADDR);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
    end
  end

  // Payload captured only on a matching write
  always_ff @(posedge clk) begin
    if (status_hit) begin
      // Only the low half carries the status code
      status_val_q <= chip_dbg_pkg::sw_status_e'(wdata_i[15:0]);
    end
    if (log_hit) begin
      log_data_q <= wdata_i;
    end
  end

  assign status_valid_o = status_valid_q;
  assign status_val_o   = status_val_q;
  assign log_valid_o    = log_valid_q;
  assign log_data_o     = log_data_q;

endmodule

// ==== src/test_status_fsm.sv ====
/*
 * Test status FSM
 * Follows software status reports and timer expiry to a final verdict
 */

`timescale 1ns/1ps

module test_status_fsm (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      status_valid_i,
  input  chip_dbg_pkg::sw_status_e  status_val_i,
  input  logic                      expire_i,
  output chip_dbg_pkg::test_state_e state_o,
  output logic                      run_o,
  output logic                      test_done_o,
  output logic                      test_passed_o
);

  chip_dbg_pkg::test_state_e state_q;
  chip_dbg_pkg::test_state_e state_d;
  logic                      final_st;

  assign final_st = (state_q == chip_dbg_pkg::TS_PASS) ||
                    (state_q == chip_dbg_pkg::TS_FAIL) ||
                    (state_q == chip_dbg_pkg::TS_TIMEOUT);

  always_comb begin
    state_d = state_q;
    if (state_q == chip_dbg_pkg::TS_RESET) begin
      state_d = chip_dbg_pkg::TS_BOOT;
    end
    // Software report takes priority over a timeout in the same cycle
    if (status_valid_i && !final_st) begin
      case (status_val_i)
        chip_dbg_pkg::ST_IN_BOOT: state_d = chip_dbg_pkg::TS_BOOT;
        chip_dbg_pkg::ST_IN_TEST: begin
          if (state_q == chip_dbg_pkg::TS_BOOT) begin
            state_d = chip_dbg_pkg::TS_TEST;
          end
        end
        chip_dbg_pkg::ST_PASSED: begin
          if (state_q == chip_dbg_pkg::TS_TEST) begin
            state_d = chip_dbg_pkg::TS_PASS;
          end
        end
        chip_dbg_pkg::ST_FAILED: begin
          if (state_q == chip_dbg_pkg::TS_TEST) begin
            state_d = chip_dbg_pkg::TS_FAIL;
          end
        end
        default: ;  // unknown code leaves the state
      endcase
    end else if (expire_i && state_q == chip_dbg_pkg::TS_TEST) begin
      state_d = chip_dbg_pkg::TS_TIMEOUT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= chip_dbg_pkg::TS_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Levels decoded from the state register
  assign state_o       = state_q;
  assign run_o         = (state_q == chip_dbg_pkg::TS_TEST);
  assign test_done_o   = final_st;
  assign test_passed_o = (state_q == chip_dbg_pkg::TS_PASS);

endmodule

// ==== src/test_timer.sv ====
/*
 * Test timer
 * Counts test cycles and flags expiry at the terminal count
 */

`timescale 1ns/1ps

module test_timer (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           run_i,
  output logic                           expire_o,
  output logic [chip_dbg_pkg::TMR_W-1:0] elapsed_o
);

  logic                           run_q;
  logic                           start;
  logic [chip_dbg_pkg::TMR_W-1:0] count_q;

  // First cycle of a new test
  assign start = run_i & ~run_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      run_q   <= 1'b0;
      count_q <= '0;
    end else begin
      run_q <= run_i;
      if (start) begin
        count_q <= '0;
      end else if (run_i && count_q != chip_dbg_pkg::TMR_LAST) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Stale count from a previous test is masked on the start cycle
  assign expire_o  = run_i && !start && (count_q == chip_dbg_pkg::TMR_LAST);
  assign elapsed_o = count_q;

endmodule

// ==== tb.f ====
src/chip_dbg_pkg.sv
src/dps_pad_mux.sv
src/ram_main.sv
src/sw_mail_snoop.sv
src/test_status_fsm.sv
src/test_timer.sv
src/chip_dbg_top.sv
test/chip_dbg_chk.sv
test/tb_chip_dbg.sv

// ==== test/chip_dbg_chk.sv ====
/*
 * Assertion checker for the chip debug top
 * Pad routing, RAM reads, mailbox snoop, status FSM and timer rules
 */

`timescale 1ns/1ps

module chip_dbg_chk (
  input logic                            clk,
  input logic                            rst_i,
  input logic                            jtag_spi_n_i,
  input logic                            jtag_tck_i,
  input logic                            jtag_tms_i,
  input logic                            jtag_tdi_i,
  input logic                            jtag_trst_n_i,
  input logic                            spi_sck_i,
  input logic                            spi_csb_i,
  input logic                            spi_sdi_i,
  input logic                            jtag_tdo_o,
  input logic                            spi_sdo_o,
  input logic                            dps_i,
  input logic [4:0]                      dps_o,
  input logic                            ram_req_i,
  input logic                            ram_write_i,
  input logic [chip_dbg_pkg::RAM_AW-1:0] ram_addr_i,
  input logic [chip_dbg_pkg::DW-1:0]     ram_wdata_i,
  input logic [chip_dbg_pkg::DW-1:0]     ram_rdata_o,
  input logic                            ram_rvalid_o,
  input logic                            log_valid_o,
  input logic [chip_dbg_pkg::DW-1:0]     log_data_o,
  input chip_dbg_pkg::test_state_e       test_state_o,
  input logic                            test_done_o,
  input logic                            test_passed_o,
  input logic [chip_dbg_pkg::TMR_W-1:0]  test_elapsed_o,
  input logic                            dps_sel_jtag_o
);

  int unsigned fail_cnt = 0;

  logic [chip_dbg_pkg::DW-1:0]         shadow_q [2 ** chip_dbg_pkg::RAM_AW];
  logic [2 ** chip_dbg_pkg::RAM_AW-1:0] written_q;
  logic                                rd_q;
  logic                                rd_known_q;
  logic [chip_dbg_pkg::DW-1:0]         exp_rdata_q;
  logic                                log_q;
  logic [chip_dbg_pkg::DW-1:0]         exp_log_q;
  logic                                wr_hit;
  logic                                st_wr;
  logic                                log_wr;
  logic [15:0]                         st_code;
  logic                                final_st;
  logic [6:0]                          route_exp;

  assign wr_hit  = ram_req_i & ram_write_i;
  assign st_wr   = wr_hit && (ram_addr_i == chip_dbg_pkg::SW_STATUS_ADDR);
  assign log_wr  = wr_hit && (ram_addr_i == chip_dbg_pkg::SW_LOG_ADDR);
  assign st_code = ram_wdata_i[15:0];

  assign final_st = test_state_o inside {chip_dbg_pkg::TS_PASS, chip_dbg_pkg::TS_FAIL,
                                         chip_dbg_pkg::TS_TIMEOUT};

  // Expected pads 4..0 followed by jtag_tdo_o and spi_sdo_o
  assign route_exp = dps_sel_jtag_o ?
    {jtag_trst_n_i, jtag_tms_i, 1'b0, jtag_tdi_i, jtag_tck_i, dps_i, 1'b0} :
    {jtag_trst_n_i, spi_csb_i, 1'b0, spi_sdi_i, spi_sck_i, 1'b0, dps_i};

  // Reference for reads and log words
  always_ff @(posedge clk) begin
    if (rst_i) begin
      written_q  <= '0;
      rd_q       <= 1'b0;
      rd_known_q <= 1'b0;
      log_q      <= 1'b0;
    end else begin
      rd_q       <= ram_req_i & ~ram_write_i;
      rd_known_q <= ram_req_i & ~ram_write_i & written_q[ram_addr_i];
      log_q      <= log_wr;
      if (wr_hit) begin
        written_q[ram_addr_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      shadow_q[ram_addr_i] <= ram_wdata_i;
    end
    if (ram_req_i && !ram_write_i) begin
      exp_rdata_q <= shadow_q[ram_addr_i];
    end
    if (log_wr) begin
      exp_log_q <= ram_wdata_i;
    end
  end

  a_route: assert property (@(posedge clk) disable iff (rst_i)
    {dps_o, jtag_tdo_o, spi_sdo_o} == route_exp)
    else begin
      $error("mismatch {dps_o,jtag_tdo_o,spi_sdo_o} got %h exp %h",
             $sampled({dps_o, jtag_tdo_o, spi_sdo_o}), $sampled(route_exp));
      fail_cnt++;
    end

  a_sel_latch: assert property (@(posedge clk)
    $fell(rst_i) |-> dps_sel_jtag_o == $past(jtag_spi_n_i))
    else begin
      $error("mismatch dps_sel_jtag_o got %h exp %h",
             $sampled(dps_sel_jtag_o), $past(jtag_spi_n_i));
      fail_cnt++;
    end

  a_sel_hold: assert property (@(posedge clk) disable iff (rst_i)
    !$past(rst_i) |-> $stable(dps_sel_jtag_o))
    else begin
      $error("strap select changed while reset was low");
      fail_cnt++;
    end

  a_ram_read: assert property (@(posedge clk) disable iff (rst_i)
    ram_rvalid_o == rd_q && (!rd_known_q || ram_rdata_o == exp_rdata_q))
    else begin
      $error("mismatch ram_rvalid_o/ram_rdata_o got %h/%h exp %h/%h",
             $sampled(ram_rvalid_o), $sampled(ram_rdata_o), $sampled(rd_q),
             $sampled(exp_rdata_q));
      fail_cnt++;
    end

  a_log: assert property (@(posedge clk) disable iff (rst_i)
    log_valid_o == log_q && (!log_q || log_data_o == exp_log_q))
    else begin
      $error("mismatch log_valid_o/log_data_o got %h/%h exp %h/%h",
             $sampled(log_valid_o), $sampled(log_data_o), $sampled(log_q),
             $sampled(exp_log_q));
      fail_cnt++;
    end

  a_reset_exit: assert property (@(posedge clk) disable iff (rst_i)
    $fell(rst_i) |=> test_state_o == chip_dbg_pkg::TS_BOOT)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_BOOT);
      fail_cnt++;
    end

  a_to_boot: assert property (@(posedge clk) disable iff (rst_i)
    st_wr && st_code == chip_dbg_pkg::ST_IN_BOOT ##1 !final_st
    |=> test_state_o == chip_dbg_pkg::TS_BOOT)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_BOOT);
      fail_cnt++;
    end

  a_to_test: assert property (@(posedge clk) disable iff (rst_i)
    st_wr && st_code == chip_dbg_pkg::ST_IN_TEST ##1 test_state_o == chip_dbg_pkg::TS_BOOT
    |=> test_state_o == chip_dbg_pkg::TS_TEST)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_TEST);
      fail_cnt++;
    end

  a_to_pass: assert property (@(posedge clk) disable iff (rst_i)
    st_wr && st_code == chip_dbg_pkg::ST_PASSED ##1 test_state_o == chip_dbg_pkg::TS_TEST
    |=> test_state_o == chip_dbg_pkg::TS_PASS)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_PASS);
      fail_cnt++;
    end

  a_to_fail: assert property (@(posedge clk) disable iff (rst_i)
    st_wr && st_code == chip_dbg_pkg::ST_FAILED ##1 test_state_o == chip_dbg_pkg::TS_TEST
    |=> test_state_o == chip_dbg_pkg::TS_FAIL)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_FAIL);
      fail_cnt++;
    end

  a_unknown: assert property (@(posedge clk) disable iff (rst_i)
    st_wr && !(st_code inside {chip_dbg_pkg::ST_IN_BOOT, chip_dbg_pkg::ST_IN_TEST,
                               chip_dbg_pkg::ST_PASSED, chip_dbg_pkg::ST_FAILED})
    ##1 (test_state_o != chip_dbg_pkg::TS_RESET && test_state_o != chip_dbg_pkg::TS_TEST)
    |=> $stable(test_state_o))
    else begin
      $error("unknown status code moved the state machine");
      fail_cnt++;
    end

  a_final_hold: assert property (@(posedge clk) disable iff (rst_i)
    final_st |=> $stable(test_state_o) && $stable(test_elapsed_o))
    else begin
      $error("final state or elapsed count changed before reset");
      fail_cnt++;
    end

  a_levels: assert property (@(posedge clk) disable iff (rst_i)
    test_done_o == final_st && test_passed_o == (test_state_o == chip_dbg_pkg::TS_PASS))
    else begin
      $error("mismatch test_done_o/test_passed_o got %h/%h for state %h",
             $sampled(test_done_o), $sampled(test_passed_o), $sampled(test_state_o));
      fail_cnt++;
    end

  a_timeout: assert property (@(posedge clk) disable iff (rst_i)
    $rose(test_state_o == chip_dbg_pkg::TS_TEST) ##1
    (test_state_o == chip_dbg_pkg::TS_TEST) [*chip_dbg_pkg::TIMEOUT_CYCLES]
    |=> test_state_o == chip_dbg_pkg::TS_TIMEOUT)
    else begin
      $error("mismatch test_state_o got %h exp %h", $sampled(test_state_o),
             chip_dbg_pkg::TS_TIMEOUT);
      fail_cnt++;
    end

  a_no_early: assert property (@(posedge clk) disable iff (rst_i)
    $rose(test_state_o == chip_dbg_pkg::TS_TEST) |->
    ##1 (test_state_o != chip_dbg_pkg::TS_TIMEOUT) [*chip_dbg_pkg::TIMEOUT_CYCLES])
    else begin
      $error("timeout reached before the full test length");
      fail_cnt++;
    end

  a_elapsed_clear: assert property (@(posedge clk) disable iff (rst_i)
    $rose(test_state_o == chip_dbg_pkg::TS_TEST) |=> test_elapsed_o == '0)
    else begin
      $error("mismatch test_elapsed_o got %h exp %h", $sampled(test_elapsed_o), 0);
      fail_cnt++;
    end

  a_elapsed_max: assert property (@(posedge clk) disable iff (rst_i)
    test_state_o == chip_dbg_pkg::TS_TIMEOUT
    |-> test_elapsed_o == chip_dbg_pkg::TIMEOUT_CYCLES - 1)
    else begin
      $error("mismatch test_elapsed_o got %h exp %h", $sampled(test_elapsed_o),
             chip_dbg_pkg::TIMEOUT_CYCLES - 1);
      fail_cnt++;
    end

endmodule

// ==== test/tb_chip_dbg.sv ====
/*
 * Testbench for the chip debug and test-status top
 * Drives the debug pads, the RAM port and mailbox writes test by test
 */

`timescale 1ns/1ps

module tb_chip_dbg;

  logic                            clk;
  logic                            rst_i;
  logic                            jtag_spi_n_i;
  logic                            jtag_tck_i;
  logic                            jtag_tms_i;
  logic                            jtag_tdi_i;
  logic                            jtag_trst_n_i;
  logic                            spi_sck_i;
  logic                            spi_csb_i;
  logic                            spi_sdi_i;
  logic                            jtag_tdo_o;
  logic                            spi_sdo_o;
  logic                            dps_i;
  logic [4:0]                      dps_o;
  logic                            ram_req_i;
  logic                            ram_write_i;
  logic [chip_dbg_pkg::RAM_AW-1:0] ram_addr_i;
  logic [chip_dbg_pkg::DW-1:0]     ram_wdata_i;
  logic [chip_dbg_pkg::DW-1:0]     ram_rdata_o;
  logic                            ram_rvalid_o;
  logic                            log_valid_o;
  logic [chip_dbg_pkg::DW-1:0]     log_data_o;
  chip_dbg_pkg::test_state_e       test_state_o;
  logic                            test_done_o;
  logic                            test_passed_o;
  logic [chip_dbg_pkg::TMR_W-1:0]  test_elapsed_o;
  logic                            dps_sel_jtag_o;

  int unsigned                     tb_err;
  int unsigned                     tests_run;
  int unsigned                     err_mark;
  logic [31:0]                     rnd_state;
  logic [chip_dbg_pkg::RAM_AW-1:0] wr_addr [16];

  // Rough cycle count of each test in run order
  int unsigned test_len [6] = '{72, 48, 32, 40, 48, 240};

  chip_dbg_top uut (.*);

  bind chip_dbg_top chip_dbg_chk u_chk (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_random();
    rnd_state ^= rnd_state << 13;
    rnd_state ^= rnd_state >> 17;
    rnd_state ^= rnd_state << 5;
    return rnd_state;
  endfunction

  function automatic int unsigned error_total();
    return tb_err + uut.u_chk.fail_cnt;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Strap wanders during reset and settles on the last cycle
  task automatic apply_reset(input logic strap);
    logic [31:0] r;
    rst_i     = 1'b1;
    ram_req_i = 1'b0;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      jtag_spi_n_i = (i == 7) ? strap : r[0];
      next_cycle();
    end
    rst_i = 1'b0;
  endtask

  task automatic drive_pads();
    logic [31:0] r;
    r = next_random();
    jtag_tck_i    = r[0];
    jtag_tms_i    = r[1];
    jtag_tdi_i    = r[2];
    jtag_trst_n_i = r[3];
    spi_sck_i     = r[4];
    spi_csb_i     = r[5];
    spi_sdi_i     = r[6];
    dps_i         = r[7];
  endtask

  task automatic ram_write(input logic [chip_dbg_pkg::RAM_AW-1:0] addr,
                           input logic [chip_dbg_pkg::DW-1:0] data);
    ram_req_i   = 1'b1;
    ram_write_i = 1'b1;
    ram_addr_i  = addr;
    ram_wdata_i = data;
    next_cycle();
    ram_req_i   = 1'b0;
    ram_write_i = 1'b0;
  endtask

  task automatic ram_read(input logic [chip_dbg_pkg::RAM_AW-1:0] addr);
    ram_req_i   = 1'b1;
    ram_write_i = 1'b0;
    ram_addr_i  = addr;
    next_cycle();
    ram_req_i   = 1'b0;
  endtask

  // Upper half is noise since the FSM only sees the low half
  task automatic status_write(input logic [15:0] code);
    logic [31:0] r;
    r = next_random();
    ram_write(chip_dbg_pkg::SW_STATUS_ADDR, {r[31:16], code});
    repeat (2) next_cycle();
  endtask

  task automatic wait_done(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (!test_done_o && n < limit) begin
      next_cycle();
      n++;
    end
    if (!test_done_o) begin
      $display("test_done_o did not rise within %0d cycles", limit);
      tb_err++;
    end
  endtask

  task automatic finish_test(input string name);
    repeat (4) next_cycle();
    tests_run++;
    $display("test %-8s finished, %0d new errors", name, error_total() - err_mark);
    err_mark = error_total();
  endtask

  initial begin
    logic [31:0] r;
    clk           = 1'b0;
    rst_i         = 1'b1;
    jtag_spi_n_i  = 1'b1;
    jtag_tck_i    = 1'b0;
    jtag_tms_i    = 1'b0;
    jtag_tdi_i    = 1'b0;
    jtag_trst_n_i = 1'b1;
    spi_sck_i     = 1'b0;
    spi_csb_i     = 1'b1;
    spi_sdi_i     = 1'b0;
    dps_i         = 1'b0;
    ram_req_i     = 1'b0;
    ram_write_i   = 1'b0;
    ram_addr_i    = '0;
    ram_wdata_i   = '0;
    rnd_state     = 32'd61;
    tb_err        = 0;
    tests_run     = 0;
    err_mark      = 0;

    // JTAG first and SPI second with the strap toggling after reset
    for (int s = 1; s >= 0; s--) begin
      apply_reset(s[0]);
      repeat (24) begin
        drive_pads();
        jtag_spi_n_i = ~jtag_spi_n_i;
        next_cycle();
      end
    end
    finish_test("pads");

    for (int i = 0; i < 16; i++) begin
      r = next_random();
      wr_addr[i] = r[5:0] % 6'd62;
      ram_write(wr_addr[i], next_random());
    end
    for (int i = 0; i < 16; i++) begin
      ram_read(wr_addr[i]);
    end
    ram_write(6'd5, next_random());
    ram_read(6'd5);
    finish_test("ram");

    for (int i = 0; i < 6; i++) begin
      ram_write(chip_dbg_pkg::SW_LOG_ADDR, next_random());
      r = next_random();
      ram_write(r[5:0] % 6'd62, next_random());
      ram_read(chip_dbg_pkg::SW_LOG_ADDR);
    end
    finish_test("log");

    apply_reset(1'b1);
    status_write(chip_dbg_pkg::ST_IN_BOOT);
    status_write(chip_dbg_pkg::ST_IN_TEST);
    status_write(chip_dbg_pkg::ST_PASSED);
    wait_done(8);
    status_write(chip_dbg_pkg::ST_FAILED);
    status_write(16'h1234);
    finish_test("pass");

    // Includes a drop back to BOOT and a second entry to TEST
    apply_reset(1'b0);
    status_write(chip_dbg_pkg::ST_IN_BOOT);
    status_write(16'h0bad);
    status_write(chip_dbg_pkg::ST_IN_TEST);
    status_write(chip_dbg_pkg::ST_IN_BOOT);
    status_write(chip_dbg_pkg::ST_IN_TEST);
    status_write(chip_dbg_pkg::ST_FAILED);
    wait_done(8);
    status_write(chip_dbg_pkg::ST_IN_BOOT);
    finish_test("fail");

    r = next_random();
    apply_reset(r[0]);
    status_write(chip_dbg_pkg::ST_IN_BOOT);
    status_write(chip_dbg_pkg::ST_IN_TEST);
    wait_done(chip_dbg_pkg::TIMEOUT_CYCLES + 16);
    finish_test("timeout");

    $display("tests run %0d, errors %0d", tests_run, error_total());
    if (error_total() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned budget;
    budget = 2 * (test_len.sum() + chip_dbg_pkg::TIMEOUT_CYCLES);
    repeat (budget) @(posedge clk);
    $display("watchdog: the run hung and did not finish within %0d cycles", budget);
    $display("Errors found");
    $finish;
  end

endmodule
